/* hdl/mul_pkg.sv */
/* Multiply unit shared definitions
   Operation codes, widths, credit depths and the 64-bit product word */
`default_nettype none

package mul_pkg;

	////////////////////////////////////////////////////////////////////
	// Widths and depths
	////////////////////////////////////////////////////////////////////

	// Operand and result word
	localparam int XLEN = 32;
	// Tag carried alongside every command
	localparam int TAG_W = 4;
	// Queue slots and initial producer credits
	localparam int CMD_DEPTH = 4;
	localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
	// Consumer credits held by the result buffer out of reset
	localparam int RSP_CREDITS = 2;
	localparam int RSP_CNT_W = $clog2(RSP_CREDITS + 1);
	localparam logic [RSP_CNT_W-1:0] RSP_CNT_MAX = RSP_CNT_W'(RSP_CREDITS);
	// Radix-16 iteration over the second operand
	localparam int DIGIT_W = 4;
	localparam int DIGIT_STEPS = 8;
	localparam int STEP_W = $clog2(DIGIT_STEPS);
	localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(DIGIT_STEPS - 1);

	////////////////////////////////////////////////////////////////////
	// Operations and product
	////////////////////////////////////////////////////////////////////

	// Low two bits of the RV32M funct3 field
	typedef enum logic [1:0] {
		OP_MUL    = 2'b00,
		OP_MULH   = 2'b01,
		OP_MULHSU = 2'b10,
		OP_MULHU  = 2'b11
	} mul_op_e;

	typedef struct packed {
		logic [XLEN-1:0] hi;
		logic [XLEN-1:0] lo;
	} mul_halves_s;

	// Full product word, or its two halves for sign fix and selection
	typedef union packed {
		logic [2*XLEN-1:0] word;
		mul_halves_s       half;
	} mul_product_u;

endpackage

`default_nettype wire

/* hdl/mul_cmd_queue.sv */
/* Multiply unit command queue
   Credit-based input FIFO that sign-tags both operands at its head */
`timescale 1ns/10ps
`default_nettype none

module mul_cmd_queue (
	input  wire                       clk,
	input  wire                       rstn,
	input  wire                       cmd_valid,
	input  wire mul_pkg::mul_op_e     cmd_op,
	input  wire [mul_pkg::XLEN-1:0]   cmd_a,
	input  wire [mul_pkg::XLEN-1:0]   cmd_b,
	input  wire [mul_pkg::TAG_W-1:0]  cmd_tag,
	input  wire                       core_idle,
	output logic                      cmd_credit,
	output logic                      issue_valid,
	output logic [mul_pkg::XLEN:0]    issue_a33,
	output logic [mul_pkg::XLEN:0]    issue_b33,
	output mul_pkg::mul_op_e          issue_op,
	output logic [mul_pkg::TAG_W-1:0] issue_tag
);

	// Storage slots
	mul_pkg::mul_op_e           op_mem  [mul_pkg::CMD_DEPTH];
	logic [mul_pkg::XLEN-1:0]   a_mem   [mul_pkg::CMD_DEPTH];
	logic [mul_pkg::XLEN-1:0]   b_mem   [mul_pkg::CMD_DEPTH];
	logic [mul_pkg::TAG_W-1:0]  tag_mem [mul_pkg::CMD_DEPTH];

	logic [mul_pkg::CMD_PTR_W-1:0] wr_ptr;
	logic [mul_pkg::CMD_PTR_W-1:0] rd_ptr;
	// One extra bit so that a full queue is distinct from empty
	logic [mul_pkg::CMD_PTR_W:0]   count;
	logic                          deq;
	logic                          a_signed;
	logic                          b_signed;
	logic [mul_pkg::XLEN-1:0]      head_a;
	logic [mul_pkg::XLEN-1:0]      head_b;

	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			op_mem[wr_ptr]  <= cmd_op;
			a_mem[wr_ptr]   <= cmd_a;
			b_mem[wr_ptr]   <= cmd_b;
			tag_mem[wr_ptr] <= cmd_tag;
		end
	end

	// Head entry leaves when the core is free to take it
	assign issue_valid = (count != '0);
	assign deq         = issue_valid && core_idle;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			cmd_credit <= 1'b0;
		end else begin
			if (cmd_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (deq)
				rd_ptr <= rd_ptr + 1'b1;
			case ({cmd_valid, deq})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// One credit back per departed command
			cmd_credit <= deq;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Operand sign tagging
	////////////////////////////////////////////////////////////////////

	assign issue_op  = op_mem[rd_ptr];
	assign issue_tag = tag_mem[rd_ptr];
	assign head_a    = a_mem[rd_ptr];
	assign head_b    = b_mem[rd_ptr];

	always_comb begin
		case (issue_op)
			mul_pkg::OP_MUL,
			mul_pkg::OP_MULH:   {a_signed, b_signed} = 2'b11;
			mul_pkg::OP_MULHSU: {a_signed, b_signed} = 2'b10;
			default:            {a_signed, b_signed} = 2'b00;
		endcase
	end

	// Bit 32 carries the sign, zero for unsigned operands
	assign issue_a33 = {a_signed & head_a[mul_pkg::XLEN-1], head_a};
	assign issue_b33 = {b_signed & head_b[mul_pkg::XLEN-1], head_b};

	// A write into a full queue means the producer spent a credit it did not hold
	a_no_overrun: assert property (@(posedge clk) disable iff (!rstn)
		cmd_valid |-> (count != mul_pkg::CMD_DEPTH))
		else $error("command written into a full queue");

endmodule

`default_nettype wire

/* hdl/mul_seq_core.sv */
/* Iterative 33x33 signed multiplier
   Magnitude load, eight radix-16 steps and a two-half sign fix */
`timescale 1ns/10ps
`default_nettype none

module mul_seq_core (
	input  wire                       clk,
	input  wire                       rstn,
	input  wire                       issue_valid,
	input  wire [mul_pkg::XLEN:0]     issue_a33,
	input  wire [mul_pkg::XLEN:0]     issue_b33,
	input  wire mul_pkg::mul_op_e     issue_op,
	input  wire [mul_pkg::TAG_W-1:0]  issue_tag,
	input  wire                       prod_ack,
	output logic                      core_idle,
	output logic                      prod_valid,
	output mul_pkg::mul_product_u     prod,
	output mul_pkg::mul_op_e          prod_op,
	output logic [mul_pkg::TAG_W-1:0] prod_tag
);

	typedef enum logic [1:0] {
		S_IDLE = 2'b00,
		S_COMP = 2'b01,
		S_FIX  = 2'b10,
		S_HOLD = 2'b11
	} core_state_e;

	core_state_e                        state;
	logic [mul_pkg::STEP_W-1:0]         step;
	logic                               accept;
	// Unsigned magnitudes of the two operands
	logic [mul_pkg::XLEN-1:0]           src1;
	logic [mul_pkg::XLEN-1:0]           src2;
	logic                               neg;
	// Low half of the raw product was all zero
	logic                               lo_zero;
	logic [mul_pkg::XLEN+mul_pkg::DIGIT_W-1:0] partial;
	logic [2*mul_pkg::XLEN-1:0]         sum_next;

	// Two's complement magnitude of a sign-tagged operand
	function automatic logic [mul_pkg::XLEN-1:0] mag32(input logic [mul_pkg::XLEN:0] v);
		logic [mul_pkg::XLEN-1:0] low;
		low = v[mul_pkg::XLEN-1:0];
		return v[mul_pkg::XLEN] ? (~low + 1'b1) : low;
	endfunction

	assign core_idle  = (state == S_IDLE);
	assign prod_valid = (state == S_HOLD);
	assign accept     = issue_valid && core_idle;

	////////////////////////////////////////////////////////////////////
	// Digit step datapath
	////////////////////////////////////////////////////////////////////

	// Top digit of the multiplier times the full multiplicand
	assign partial = src1 * src2[mul_pkg::XLEN-1 -: mul_pkg::DIGIT_W];

	// Running sum moves up one digit before the new partial is added
	assign sum_next = {prod.word[2*mul_pkg::XLEN-mul_pkg::DIGIT_W-1:0], {mul_pkg::DIGIT_W{1'b0}}}
		+ {{(mul_pkg::XLEN-mul_pkg::DIGIT_W){1'b0}}, partial};

	always_ff @(posedge clk) begin
		if (accept) begin
			src1      <= mag32(issue_a33);
			src2      <= mag32(issue_b33);
			neg       <= issue_a33[mul_pkg::XLEN] ^ issue_b33[mul_pkg::XLEN];
			prod.word <= '0;
			prod_op   <= issue_op;
			prod_tag  <= issue_tag;
		end else if (state == S_COMP) begin
			prod.word <= sum_next;
			src2      <= src2 << mul_pkg::DIGIT_W;
			lo_zero   <= ~|sum_next[mul_pkg::XLEN-1:0];
		end else if ((state == S_FIX) && neg) begin
			// Negate low half, carry into high half only out of an all-zero low half
			prod.half.lo <= ~prod.half.lo + 1'b1;
			prod.half.hi <= lo_zero ? (~prod.half.hi + 1'b1) : ~prod.half.hi;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= S_IDLE;
			step  <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (issue_valid) begin
						state <= S_COMP;
						step  <= '0;
					end
				end
				S_COMP: begin
					step <= step + 1'b1;
					if (step == mul_pkg::LAST_STEP)
						state <= S_FIX;
				end
				S_FIX:
					state <= S_HOLD;
				// Result stays put until the buffer takes it
				S_HOLD: begin
					if (prod_ack)
						state <= S_IDLE;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// Buffer may only take a product that is on offer
	a_ack_in_hold: assert property (@(posedge clk) disable iff (!rstn)
		prod_ack |-> prod_valid)
		else $error("product acknowledged while none held");

endmodule

`default_nettype wire

/* hdl/mul_result_buf.sv */
/* Multiply unit result buffer
   Picks the product half and sends it out against consumer credits */
`timescale 1ns/10ps
`default_nettype none

module mul_result_buf (
	input  wire                       clk,
	input  wire                       rstn,
	input  wire                       prod_valid,
	input  wire mul_pkg::mul_product_u prod,
	input  wire mul_pkg::mul_op_e     prod_op,
	input  wire [mul_pkg::TAG_W-1:0]  prod_tag,
	input  wire                       rsp_credit,
	output logic                      prod_ack,
	output logic                      rsp_valid,
	output logic [mul_pkg::XLEN-1:0]  rsp_data,
	output logic [mul_pkg::TAG_W-1:0] rsp_tag
);

	// Holding register has a word not yet sent
	logic                             full;
	logic [mul_pkg::RSP_CNT_W-1:0]    crd_cnt;

	// Send the held word whenever the consumer has room
	assign rsp_valid = full && (crd_cnt != '0);

	// Take a product into an empty slot, or one emptied this cycle
	assign prod_ack = prod_valid && (!full || rsp_valid);

	always_ff @(posedge clk) begin
		if (prod_ack) begin
			// MUL returns the low half, every other op the high half
			rsp_data <= (prod_op == mul_pkg::OP_MUL) ? prod.half.lo : prod.half.hi;
			rsp_tag  <= prod_tag;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			full    <= 1'b0;
			crd_cnt <= mul_pkg::RSP_CNT_MAX;
		end else begin
			if (prod_ack)
				full <= 1'b1;
			else if (rsp_valid)
				full <= 1'b0;

			// Credit in from consumer, credit out with each response
			case ({rsp_credit, rsp_valid})
				2'b10:   crd_cnt <= crd_cnt + 1'b1;
				2'b01:   crd_cnt <= crd_cnt - 1'b1;
				default: crd_cnt <= crd_cnt;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////
	// Credit checks
	////////////////////////////////////////////////////////////////////

	// Extra credits from the consumer push the count past its start value,
	// a send at zero would wrap it to the top code, both land above the bound
	a_crd_bound: assert property (@(posedge clk) disable iff (!rstn)
		crd_cnt <= mul_pkg::RSP_CNT_MAX)
		else $error("consumer credit count out of range");

endmodule

`default_nettype wire

/* hdl/mul_unit_top.sv */
/* Multiply unit top level
   Command queue, iterative multiplier and result buffer in a row */
`timescale 1ns/10ps
`default_nettype none

module mul_unit_top (
	input  wire                       clk,
	input  wire                       rstn,
	input  wire                       cmd_valid,
	input  wire mul_pkg::mul_op_e     cmd_op,
	input  wire [mul_pkg::XLEN-1:0]   cmd_a,
	input  wire [mul_pkg::XLEN-1:0]   cmd_b,
	input  wire [mul_pkg::TAG_W-1:0]  cmd_tag,
	input  wire                       rsp_credit,
	output logic                      cmd_credit,
	output logic                      rsp_valid,
	output logic [mul_pkg::XLEN-1:0]  rsp_data,
	output logic [mul_pkg::TAG_W-1:0] rsp_tag
);

	// Queue to core
	logic                      issue_valid;
	logic [mul_pkg::XLEN:0]    issue_a33;
	logic [mul_pkg::XLEN:0]    issue_b33;
	mul_pkg::mul_op_e          issue_op;
	logic [mul_pkg::TAG_W-1:0] issue_tag;
	logic                      core_idle;

	// Core to buffer
	logic                      prod_valid;
	mul_pkg::mul_product_u     prod;
	mul_pkg::mul_op_e          prod_op;
	logic [mul_pkg::TAG_W-1:0] prod_tag;
	logic                      prod_ack;

	mul_cmd_queue i_mul_cmd_queue (
		.clk, .rstn, .cmd_valid, .cmd_op, .cmd_a, .cmd_b, .cmd_tag, .core_idle,
		.cmd_credit, .issue_valid, .issue_a33, .issue_b33, .issue_op, .issue_tag
	);

	mul_seq_core i_mul_seq_core (
		.clk, .rstn, .issue_valid, .issue_a33, .issue_b33, .issue_op, .issue_tag,
		.prod_ack, .core_idle, .prod_valid, .prod, .prod_op, .prod_tag
	);

	mul_result_buf i_mul_result_buf (
		.clk, .rstn, .prod_valid, .prod, .prod_op, .prod_tag, .rsp_credit,
		.prod_ack, .rsp_valid, .rsp_data, .rsp_tag
	);

endmodule

`default_nettype wire

/* test/tb_mul_unit.sv */
/* Multiply unit testbench
   Directed and LFSR commands against a reference model, credits in both directions */
`timescale 1ns/10ps
`default_nettype none

module tb_mul_unit;

	localparam int NUM_DIRECTED = 16;
	localparam int NUM_ENTRIES  = 64;
	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 16;
	// Every 16th consumer credit is held back long enough to drain the result credits
	localparam int STALL_EVERY  = 16;
	localparam int STALL_CYCLES = 48;
	// About 12 core cycles plus up to 8 credit delay per entry, the long holds, then reset
	localparam int WATCHDOG_NS  = NUM_ENTRIES * (12 + 8) * CLK_PERIOD
		+ (NUM_ENTRIES / STALL_EVERY) * STALL_CYCLES * CLK_PERIOD
		+ RESET_CYCLES * CLK_PERIOD;

	logic             clk;
	logic             rstn;
	logic             cmd_valid;
	mul_pkg::mul_op_e cmd_op;
	logic [31:0]      cmd_a;
	logic [31:0]      cmd_b;
	logic [3:0]       cmd_tag;
	logic             rsp_credit;
	logic             cmd_credit;
	logic             rsp_valid;
	logic [31:0]      rsp_data;
	logic [3:0]       rsp_tag;

	// Stimulus and expected word per entry
	mul_pkg::mul_op_e tbl_op  [NUM_ENTRIES];
	logic [31:0]      tbl_a   [NUM_ENTRIES];
	logic [31:0]      tbl_b   [NUM_ENTRIES];
	logic [3:0]       tbl_tag [NUM_ENTRIES];
	logic [31:0]      tbl_exp [NUM_ENTRIES];

	logic [15:0] lfsr;
	int prod_credits = 0;
	int sent = 0;
	int rsp_count = 0;
	// Consumer credits handed back, and responses still owed one
	int crd_returned = 0;
	int pending = 0;
	int credit_pulses = 0;
	int post_rst = 0;
	int data_errs = 0;
	int tag_errs = 0;
	int proto_errs = 0;

	mul_unit_top i_mul_unit_top (
		.clk, .rstn, .cmd_valid, .cmd_op, .cmd_a, .cmd_b, .cmd_tag, .rsp_credit,
		.cmd_credit, .rsp_valid, .rsp_data, .rsp_tag
	);

	// Fibonacci LFSR x^16+x^14+x^13+x^11+1, one step per bit taken
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[15]};
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		end
		return v;
	endfunction

	// RV32M result from 64-bit extended operands
	function automatic logic [31:0] ref_result(input mul_pkg::mul_op_e op,
		input logic [31:0] a, input logic [31:0] b);
		logic [63:0] ea;
		logic [63:0] eb;
		logic [63:0] p;
		// rs1 signed unless MULHU, rs2 signed only for MUL and MULH
		ea = (op == mul_pkg::OP_MULHU) ? {32'h0, a} : {{32{a[31]}}, a};
		eb = (op == mul_pkg::OP_MUL || op == mul_pkg::OP_MULH) ? {{32{b[31]}}, b} : {32'h0, b};
		p  = ea * eb;
		return (op == mul_pkg::OP_MUL) ? p[31:0] : p[63:32];
	endfunction

	task automatic set_entry(input int idx, input mul_pkg::mul_op_e op,
		input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp_word);
		tbl_op[idx]  = op;
		tbl_a[idx]   = a;
		tbl_b[idx]   = b;
		tbl_tag[idx] = 4'(idx);
		tbl_exp[idx] = exp_word;
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////
	// Producer
	////////////////////////////////////////////////////////////////////

	initial begin : producer
		logic [31:0] r;
		cmd_valid  = 1'b0;
		cmd_op     = mul_pkg::OP_MUL;
		cmd_a      = '0;
		cmd_b      = '0;
		cmd_tag    = '0;
		rsp_credit = 1'b0;
		rstn       = 1'b0;
		lfsr       = 16'd45;
		// Signs, extremes, zeros
		set_entry(0,  mul_pkg::OP_MUL,    32'h0000_0003, 32'h0000_0005, 32'h0000_000F);
		set_entry(1,  mul_pkg::OP_MUL,    32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001);
		set_entry(2,  mul_pkg::OP_MULH,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000);
		set_entry(3,  mul_pkg::OP_MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE);
		set_entry(4,  mul_pkg::OP_MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
		set_entry(5,  mul_pkg::OP_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
		set_entry(6,  mul_pkg::OP_MUL,    32'h8000_0000, 32'h8000_0000, 32'h0000_0000);
		set_entry(7,  mul_pkg::OP_MULHU,  32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
		set_entry(8,  mul_pkg::OP_MULHSU, 32'h8000_0000, 32'h8000_0000, 32'hC000_0000);
		set_entry(9,  mul_pkg::OP_MUL,    32'h0000_0000, 32'h1234_5678, 32'h0000_0000);
		set_entry(10, mul_pkg::OP_MULH,   32'h7FFF_FFFF, 32'h0000_0000, 32'h0000_0000);
		// Negative products, some with an all-zero low half
		set_entry(11, mul_pkg::OP_MULH,   32'h0001_0000, 32'hFFFF_0000, 32'hFFFF_FFFF);
		set_entry(12, mul_pkg::OP_MULH,   32'h8000_0000, 32'h0000_0001, 32'hFFFF_FFFF);
		set_entry(13, mul_pkg::OP_MULHSU, 32'hFFFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF);
		set_entry(14, mul_pkg::OP_MULHSU, 32'hFFFF_0000, 32'h0001_0000, 32'hFFFF_FFFF);
		set_entry(15, mul_pkg::OP_MUL,    32'hFFFF_FFFE, 32'h0000_0003, 32'hFFFF_FFFA);
		for (int i = NUM_DIRECTED; i < NUM_ENTRIES; i++) begin
			r            = lfsr_bits(2);
			tbl_op[i]    = mul_pkg::mul_op_e'(r[1:0]);
			tbl_a[i]     = lfsr_bits(32);
			tbl_b[i]     = lfsr_bits(32);
			r            = lfsr_bits(4);
			tbl_tag[i]   = r[3:0];
			tbl_exp[i]   = ref_result(tbl_op[i], tbl_a[i], tbl_b[i]);
		end

		repeat (RESET_CYCLES) @(posedge clk);
		#1 rstn = 1'b1;
		prod_credits = mul_pkg::CMD_DEPTH;

		// One command per cycle while a credit is held
		while (rsp_count < NUM_ENTRIES) begin
			@(posedge clk);
			#1;
			if (cmd_credit)
				prod_credits++;
			// More credits than queue slots means one came back without a command
			if (prod_credits < 0 || prod_credits > mul_pkg::CMD_DEPTH) begin
				proto_errs++;
				$display("Producer credit count left the range from zero to queue depth");
			end
			cmd_valid = 1'b0;
			if (sent < NUM_ENTRIES && prod_credits > 0) begin
				cmd_valid = 1'b1;
				cmd_op    = tbl_op[sent];
				cmd_a     = tbl_a[sent];
				cmd_b     = tbl_b[sent];
				cmd_tag   = tbl_tag[sent];
				prod_credits--;
				sent++;
			end
		end

		// Drain, catching late credits and duplicate responses
		repeat (8) begin
			@(posedge clk);
			#1;
			if (cmd_credit)
				prod_credits++;
		end
		if (prod_credits != mul_pkg::CMD_DEPTH) begin
			proto_errs++;
			$display("Mismatch prod_credits: got %h expected %h", prod_credits, mul_pkg::CMD_DEPTH);
		end
		if (credit_pulses != sent) begin
			proto_errs++;
			$display("Mismatch cmd_credit count: got %h expected %h", credit_pulses, sent);
		end
		if (rsp_count != NUM_ENTRIES) begin
			proto_errs++;
			$display("Mismatch rsp_valid count: got %h expected %h", rsp_count, NUM_ENTRIES);
		end

		$display("Responses %0d of %0d, errors: data %0d, tag %0d, protocol %0d",
			rsp_count, NUM_ENTRIES, data_errs, tag_errs, proto_errs);
		if (data_errs + tag_errs + proto_errs == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Consumer hands each response's credit back after 0 to 7 idle cycles
	initial begin : consumer
		int delay;
		int given;
		given = 0;
		wait (rstn);
		forever begin
			wait (pending > 0);
			delay = int'(lfsr_bits(3));
			// Long hold so results pile up in the buffer and stall the core
			if (given % STALL_EVERY == STALL_EVERY - 1)
				delay += STALL_CYCLES;
			repeat (delay) @(posedge clk);
			@(posedge clk);
			#1 rsp_credit = 1'b1;
			pending--;
			given++;
			@(posedge clk);
			#1 rsp_credit = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Response checker, sampled mid-cycle
	////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (rstn)
			post_rst++;
		// Quiet outputs in reset and the first cycle out of it
		if (post_rst <= 1 && (rsp_valid !== 1'b0 || cmd_credit !== 1'b0)) begin
			proto_errs++;
			$display("Response or command credit active during or right after reset");
		end
		if (cmd_credit)
			credit_pulses++;
		if (rsp_valid) begin
			if (rsp_count >= NUM_ENTRIES) begin
				proto_errs++;
				$display("Response arrived after every command was already answered");
			end else begin
				if (rsp_data !== tbl_exp[rsp_count]) begin
					data_errs++;
					$display("Mismatch rsp_data entry %0d: got %h expected %h",
						rsp_count, rsp_data, tbl_exp[rsp_count]);
				end
				if (rsp_tag !== tbl_tag[rsp_count]) begin
					tag_errs++;
					$display("Mismatch rsp_tag entry %0d: got %h expected %h",
						rsp_count, rsp_tag, tbl_tag[rsp_count]);
				end
			end
			rsp_count++;
			pending++;
			// Only credits returned before this cycle count
			if (rsp_count > mul_pkg::RSP_CREDITS + crd_returned) begin
				proto_errs++;
				$display("Response sent without a consumer credit");
			end
		end
		if (rsp_credit)
			crd_returned++;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout with %0d of %0d responses, errors: data %0d, tag %0d, protocol %0d",
			rsp_count, NUM_ENTRIES, data_errs, tag_errs, proto_errs);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hdl/mul_pkg.sv
hdl/mul_cmd_queue.sv
hdl/mul_seq_core.sv
hdl/mul_result_buf.sv
hdl/mul_unit_top.sv
test/tb_mul_unit.sv
